/* verilog/sdmac_consts.svh */
// bus, byte and FIFO sizing macros for the SCSI DMA slice, included by RTL and testbench
`ifndef SDMAC_CONSTS_SVH
`define SDMAC_CONSTS_SVH

// CPU bus data and address width
`define SDMAC_BUS_W 32

// SCSI controller data width
`define SDMAC_BYTE_W 8

// longword entries between the SCSI side and the bus side
`define SDMAC_FIFO_DEPTH 8

// width of the longword transfer counter
`define SDMAC_CNT_W 16

`endif

/* verilog/sdmac_pkg.sv */
// shared data types and bus master state encoding, imported by the DMA blocks and testbench
`default_nettype none

`include "sdmac_consts.svh"

package sdmac_pkg;

    // one longword on the CPU bus
    typedef logic [`SDMAC_BUS_W-1:0] long_t;

    // one byte on the SCSI controller port
    typedef logic [`SDMAC_BYTE_W-1:0] scsi_byte_t;

    // count of completed longword cycles
    typedef logic [`SDMAC_CNT_W-1:0] xfer_cnt_t;

    // bus master sequence, one bus cycle runs own -> strobe -> wait_term -> release
    typedef enum logic [2:0] {
        st_idle,
        st_request,
        st_own,
        st_strobe,
        st_wait_term,
        st_release,
        st_finish
    } bus_state_t;

endpackage

`default_nettype wire

/* verilog/scsi_port.sv */
// SCSI side of the DMA slice; byte dreq/dack handshake, longword packing and flush padding
`timescale 1ns/1ns
`default_nettype none

`include "sdmac_consts.svh"

module scsi_port
    import sdmac_pkg::*;
(
    input  wire         BCLK,
    input  wire         CCRESET_,
    input  wire         dma_dir,
    input  wire         dma_ena,
    input  wire         flush,
    input  wire         dreq,
    input  wire scsi_byte_t scsi_din,
    input  wire         full,
    input  wire         empty,
    input  wire long_t  pop_data,
    output logic        dack,
    output scsi_byte_t  scsi_dout,
    output logic        push,
    output logic        pop,
    output long_t       push_data,
    output logic        flush_done
);

    localparam int BW = `SDMAC_BYTE_W;
    localparam int PAD_W = `SDMAC_BUS_W - `SDMAC_BYTE_W;

    // lane 0 is the top byte of the longword
    logic [1:0] lane;
    long_t      asm_q;
    // a packed longword is waiting to go into the FIFO
    logic       pend;
    // flush already answered, held until flush drops
    logic       flushed;
    logic       can_serve;

    // direction 0 needs room for the word being packed, direction 1 needs a word to unpack
    assign can_serve = dma_dir ? !empty : (!full && !pend);

    assign push      = pend && !full;
    assign push_data = asm_q;

    // the head word leaves the FIFO together with its last byte
    assign pop       = dack && dma_dir && (lane == 2'd3);
    assign scsi_dout = pop_data[(3 - lane) * BW +: BW];

    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            dack       <= 1'b0;
            lane       <= 2'd0;
            pend       <= 1'b0;
            flushed    <= 1'b0;
            flush_done <= 1'b0;
        end else if (!dma_ena) begin
            dack       <= 1'b0;
            lane       <= 2'd0;
            pend       <= 1'b0;
            flushed    <= 1'b0;
            flush_done <= 1'b0;
        end else begin
            flush_done <= 1'b0;
            // one pulse per byte, the device moves on after seeing it
            dack <= dreq && !dack && !flush && can_serve;

            if (push) begin
                pend <= 1'b0;
            end

            if (dack) begin
                lane <= lane + 1'b1;
                if (!dma_dir && (lane == 2'd3)) begin
                    pend <= 1'b1;
                end
            end else if (flush && !flushed) begin
                if (!dma_dir && (lane != 2'd0)) begin
                    // partial word, low lanes are already zero
                    pend <= 1'b1;
                    lane <= 2'd0;
                end else if (!pend) begin
                    flush_done <= 1'b1;
                    flushed    <= 1'b1;
                end
            end

            if (!flush) begin
                flushed <= 1'b0;
            end
        end
    end

    // big-endian packing; the first byte of a word clears the lanes below it
    always_ff @(posedge BCLK) begin
        if (dack && !dma_dir) begin
            if (lane == 2'd0) begin
                asm_q <= {scsi_din, {PAD_W{1'b0}}};
            end else begin
                asm_q[(3 - lane) * BW +: BW] <= scsi_din;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/long_fifo.sv */
// show-ahead longword FIFO decoupling the SCSI port from the bus master
`timescale 1ns/1ns
`default_nettype none

`include "sdmac_consts.svh"

module long_fifo
    import sdmac_pkg::*;
(
    input  wire        BCLK,
    input  wire        CCRESET_,
    input  wire        push,
    input  wire        pop,
    input  wire long_t push_data,
    output long_t      pop_data,
    output logic       full,
    output logic       empty
);

    localparam int DEPTH = `SDMAC_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    long_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // requests against a full or empty buffer are ignored
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge BCLK) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/cpu_bus_master.sv */
// CPU side of the DMA slice; bus arbitration, longword cycles, address/count and flush status
`timescale 1ns/1ns
`default_nettype none

module cpu_bus_master
    import sdmac_pkg::*;
(
    input  wire            BCLK,
    input  wire            CCRESET_,
    input  wire            dma_ena,
    input  wire            dma_dir,
    input  wire            flush,
    input  wire long_t     start_addr,
    input  wire xfer_cnt_t word_count,
    input  wire            bgrant,
    input  wire [1:0]      dsack_,
    input  wire            sterm_,
    input  wire long_t     data_in,
    input  wire long_t     fifo_data,
    input  wire            full,
    input  wire            empty,
    input  wire            flush_done,
    output logic           breq,
    output logic           bgack,
    output logic           as_,
    output logic           ds_,
    output logic           rw,
    output long_t          addr,
    output long_t          data_out,
    output logic           fifo_pop,
    output logic           fifo_push,
    output long_t          fifo_wdata,
    output logic           done,
    output logic           stop_flush
);

    bus_state_t state;
    logic [2:0] sync_a;
    logic [2:0] sync_b;
    logic       ena_s;
    logic       flush_s;
    logic       bgrant_s;
    xfer_cnt_t  count_q;
    logic       fdone_q;
    logic       term;
    logic       count_hit;
    logic       work;

    assign {ena_s, flush_s, bgrant_s} = sync_b;

    // 32-bit port acknowledge or synchronous termination
    assign term      = (dsack_ == 2'b00) || !sterm_;
    assign count_hit = (count_q == word_count);
    assign work      = ena_s && !count_hit && (dma_dir ? !full : !empty);

    // write data leaves the FIFO just before the strobes fall
    assign fifo_pop = (state == st_own) && !dma_dir;

    // read data goes into the FIFO on the terminating edge
    assign fifo_push  = ((state == st_strobe) || (state == st_wait_term)) && term && dma_dir;
    assign fifo_wdata = data_in;

    // enable, flush and grant arrive asynchronously
    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            sync_a <= '0;
            sync_b <= '0;
        end else begin
            sync_a <= {dma_ena, flush, bgrant};
            sync_b <= sync_a;
        end
    end

    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            state   <= st_idle;
            breq    <= 1'b0;
            bgack   <= 1'b0;
            as_     <= 1'b1;
            ds_     <= 1'b1;
            rw      <= 1'b1;
            addr    <= '0;
            count_q <= '0;
            done    <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (!ena_s) begin
                        addr    <= start_addr;
                        count_q <= '0;
                        done    <= 1'b0;
                    end else if (count_hit) begin
                        done  <= 1'b1;
                        state <= st_finish;
                    end else if (work) begin
                        breq  <= 1'b1;
                        state <= st_request;
                    end
                end
                st_request: begin
                    if (!ena_s) begin
                        breq  <= 1'b0;
                        state <= st_idle;
                    end else if (bgrant_s) begin
                        breq  <= 1'b0;
                        bgack <= 1'b1;
                        rw    <= dma_dir;
                        state <= st_own;
                    end
                end
                st_own: begin
                    as_   <= 1'b0;
                    ds_   <= 1'b0;
                    state <= st_strobe;
                end
                st_strobe, st_wait_term: begin
                    if (term) begin
                        as_     <= 1'b1;
                        ds_     <= 1'b1;
                        addr    <= addr + long_t'(4);
                        count_q <= count_q + 1'b1;
                        state   <= st_release;
                    end else begin
                        state <= st_wait_term;
                    end
                end
                st_release: begin
                    // FIFO flags already reflect the cycle that just ended
                    if (count_hit) begin
                        bgack <= 1'b0;
                        done  <= 1'b1;
                        state <= st_finish;
                    end else if (work) begin
                        rw    <= dma_dir;
                        state <= st_own;
                    end else begin
                        bgack <= 1'b0;
                        state <= st_idle;
                    end
                end
                st_finish: begin
                    if (!ena_s) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge BCLK) begin
        if (fifo_pop) begin
            data_out <= fifo_data;
        end
    end

    // flush is over once the padded word has left the FIFO and the bus is given back
    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            fdone_q    <= 1'b0;
            stop_flush <= 1'b0;
        end else begin
            if (flush_done) begin
                fdone_q <= 1'b1;
            end else if (!ena_s || (stop_flush && !flush_s)) begin
                fdone_q <= 1'b0;
            end

            if (!flush_s) begin
                stop_flush <= 1'b0;
            end else if (fdone_q && (empty || dma_dir) && !bgack) begin
                stop_flush <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/sdmac_top.sv */
// top level of the SCSI DMA slice; joins the SCSI port, longword FIFO and bus master
`timescale 1ns/1ns
`default_nettype none

module sdmac_top
    import sdmac_pkg::*;
(
    input  wire            BCLK,
    input  wire            CCRESET_,
    input  wire            dma_ena,
    input  wire            dma_dir,
    input  wire            flush,
    input  wire long_t     start_addr,
    input  wire xfer_cnt_t word_count,
    input  wire            dreq,
    output logic           dack,
    input  wire scsi_byte_t scsi_din,
    output scsi_byte_t     scsi_dout,
    output logic           breq,
    input  wire            bgrant,
    output logic           bgack,
    output logic           as_,
    output logic           ds_,
    output logic           rw,
    output long_t          addr,
    output long_t          data_out,
    input  wire long_t     data_in,
    input  wire [1:0]      dsack_,
    input  wire            sterm_,
    output logic           done,
    output logic           stop_flush
);

    logic  sp_push;
    logic  sp_pop;
    logic  bm_push;
    logic  bm_pop;
    logic  fifo_push;
    logic  fifo_pop;
    logic  full;
    logic  empty;
    logic  flush_done;
    long_t sp_push_data;
    long_t bm_wdata;
    long_t fifo_wdata;
    long_t pop_data;

    // direction 0 fills from SCSI and drains to memory, direction 1 the other way
    assign fifo_push  = dma_dir ? bm_push : sp_push;
    assign fifo_pop   = dma_dir ? sp_pop : bm_pop;
    assign fifo_wdata = dma_dir ? bm_wdata : sp_push_data;

    scsi_port u_scsi_port (
        .BCLK       (BCLK),
        .CCRESET_   (CCRESET_),
        .dma_dir    (dma_dir),
        .dma_ena    (dma_ena),
        .flush      (flush),
        .dreq       (dreq),
        .scsi_din   (scsi_din),
        .full       (full),
        .empty      (empty),
        .pop_data   (pop_data),
        .dack       (dack),
        .scsi_dout  (scsi_dout),
        .push       (sp_push),
        .pop        (sp_pop),
        .push_data  (sp_push_data),
        .flush_done (flush_done)
    );

    long_fifo u_long_fifo (
        .BCLK      (BCLK),
        .CCRESET_  (CCRESET_),
        .push      (fifo_push),
        .pop       (fifo_pop),
        .push_data (fifo_wdata),
        .pop_data  (pop_data),
        .full      (full),
        .empty     (empty)
    );

    cpu_bus_master u_cpu_bus_master (
        .BCLK       (BCLK),
        .CCRESET_   (CCRESET_),
        .dma_ena    (dma_ena),
        .dma_dir    (dma_dir),
        .flush      (flush),
        .start_addr (start_addr),
        .word_count (word_count),
        .bgrant     (bgrant),
        .dsack_     (dsack_),
        .sterm_     (sterm_),
        .data_in    (data_in),
        .fifo_data  (pop_data),
        .full       (full),
        .empty      (empty),
        .flush_done (flush_done),
        .breq       (breq),
        .bgack      (bgack),
        .as_        (as_),
        .ds_        (ds_),
        .rw         (rw),
        .addr       (addr),
        .data_out   (data_out),
        .fifo_pop   (bm_pop),
        .fifo_push  (bm_push),
        .fifo_wdata (bm_wdata),
        .done       (done),
        .stop_flush (stop_flush)
    );

endmodule

`default_nettype wire

/* tests/sdmac_tb.sv */
// testbench for the SCSI DMA slice; SCSI device and memory models, bus protocol and data checks
`timescale 1ns/1ns
`default_nettype none

`include "sdmac_consts.svh"

module sdmac_tb
    import sdmac_pkg::*;
;
    localparam int TOTAL_WORDS = 2 * 5 + `SDMAC_FIFO_DEPTH + 4 + 4;
    localparam int WORST_CYC = 64;
    localparam int WATCHDOG_NS = (TOTAL_WORDS * WORST_CYC + 800) * 10;

    logic BCLK = 1'b0, CCRESET_, dma_ena, dma_dir, flush, dreq, bgrant, sterm_;
    long_t start_addr, data_in, addr, data_out;
    xfer_cnt_t word_count;
    scsi_byte_t scsi_din, scsi_dout;
    logic [1:0] dsack_;
    logic dack, breq, bgack, as_, ds_, rw, done, stop_flush;

    logic [31:0] lfsr = 32'hfaa0;
    logic [31:0] mem [0:63];
    logic [7:0]  src [0:63];
    int byte_idx, n_bytes, rd_base, cyc_cnt, wait_n, gnt_dly;
    int proto_err = 0, data_err = 0, tmo_err = 0;
    logic taken = 0, in_cyc = 0, use_sterm = 0, slow = 0, dev_on = 0, term;
    logic p_as, p_bgack, p_term, p_done, p_stop, grant_seen;
    long_t p_addr;

    sdmac_top DUT (.*);

    always #5 BCLK = ~BCLK;

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [7:0] src_byte(input int i);
        return (i < n_bytes) ? src[i] : 8'h00;
    endfunction

    // SCSI device; moves to the next byte once the dack cycle has passed
    always @(posedge BCLK) begin
        if (dack) begin
            taken = 1'b1;
            if (dma_dir) begin
                assert (scsi_dout == mem[rd_base + byte_idx / 4][31 - 8 * (byte_idx % 4) -: 8])
                else begin
                    data_err++;
                    $display("FAIL scsi_dout byte %0d expected %h got %h", byte_idx,
                             mem[rd_base + byte_idx / 4][31 - 8 * (byte_idx % 4) -: 8], scsi_dout);
                end
            end
        end
    end

    always @(negedge BCLK) begin
        if (taken) begin
            taken = 1'b0;
            byte_idx++;
        end
        scsi_din = src[byte_idx % 64];
        dreq = dev_on && (byte_idx < n_bytes);
    end

    // memory model, random grant delay and 0 to 3 wait states, dsack and sterm in turn
    always @(negedge BCLK) begin
        if (bgack) begin
            // the next tenure gets a fresh grant delay
            if (bgrant) gnt_dly = int'(rand_bits(3));
            bgrant = 1'b0;
        end else if (breq && !bgrant) begin
            if (gnt_dly == 0) bgrant = 1'b1;
            else gnt_dly--;
        end else if (!breq) begin
            bgrant = 1'b0;
        end
        if (as_) begin
            in_cyc = 1'b0;
            dsack_ = 2'b11;
            sterm_ = 1'b1;
        end else begin
            if (!in_cyc) begin
                in_cyc = 1'b1;
                wait_n = int'(rand_bits(2)) + (slow ? 40 : 0);
            end
            if (wait_n == 0) begin
                if (!rw) mem[addr[7:2]] = data_out;
                else data_in = mem[addr[7:2]];
                if (use_sterm) sterm_ = 1'b0;
                else dsack_ = 2'b00;
                use_sterm = !use_sterm;
            end else begin
                wait_n--;
            end
        end
    end

    // bus protocol checks on values held over the previous cycle
    always @(posedge BCLK) begin
        term = (dsack_ == 2'b00) || !sterm_;
        if (CCRESET_) begin
            assert (as_ || bgack) else begin
                proto_err++;
                $display("FAIL as_ low without bgack, state %s", DUT.u_cpu_bus_master.state.name());
            end
            assert (ds_ == as_) else begin
                proto_err++;
                $display("FAIL ds_ expected %h got %h", as_, ds_);
            end
            assert (!bgack || p_bgack || grant_seen) else begin
                proto_err++;
                $display("bgack rose without a bus grant");
            end
            assert (!(breq && bgack && p_bgack)) else begin
                proto_err++;
                $display("breq and bgack both high while owning the bus");
            end
            assert (as_ || p_as || addr == p_addr) else begin
                proto_err++;
                $display("FAIL addr expected %h got %h", p_addr, addr);
            end
            assert (p_as || (as_ == p_term)) else begin
                proto_err++;
                $display("FAIL as_ expected %h got %h", p_term, as_);
            end
            assert (!(done && !p_done) || cyc_cnt == int'(word_count)) else begin
                proto_err++;
                $display("FAIL cycles at done expected %h got %h", word_count, cyc_cnt);
            end
            assert (!(p_done && !done) || !dma_ena) else begin
                proto_err++;
                $display("done fell while dma_ena was still high");
            end
            assert (!(done && !as_)) else begin
                proto_err++;
                $display("bus cycle started after done");
            end
            assert (!(stop_flush && !p_stop) || (as_ && !bgack)) else begin
                proto_err++;
                $display("stop_flush rose while the bus was still owned");
            end
            if (!as_ && term) begin
                cyc_cnt++;
                assert (rw == dma_dir) else begin
                    proto_err++;
                    $display("FAIL rw expected %h got %h", dma_dir, rw);
                end
            end
        end
        grant_seen = (grant_seen || bgrant) && !(p_bgack && !bgack);
        p_as = as_;
        p_bgack = bgack;
        p_term = term;
        p_done = done;
        p_stop = stop_flush;
        p_addr = addr;
    end

    task automatic wait_until_done(input int limit);
        int i;
        i = 0;
        while (!(done && byte_idx == n_bytes) && i < limit) begin
            @(negedge BCLK);
            i++;
        end
        if (i >= limit) begin
            tmo_err++;
            $display("timeout waiting for the transfer to complete");
        end
    endtask

    task automatic check_mem(input int base, input int words);
        long_t exp;
        for (int k = 0; k < words; k++) begin
            exp = {src_byte(4 * k), src_byte(4 * k + 1), src_byte(4 * k + 2), src_byte(4 * k + 3)};
            assert (mem[base + k] == exp) else begin
                data_err++;
                $display("FAIL mem[%h] expected %h got %h", (base + k) * 4, exp, mem[base + k]);
            end
        end
    endtask

    // one transfer; dir 0 writes SCSI bytes to memory, dir 1 reads memory to SCSI
    task automatic run_transfer(input logic dir, input int base, input int n, input logic slw);
        for (int i = 0; i < 64; i++) begin
            src[i] = 8'(rand_bits(8));
        end
        if (dir) begin
            for (int i = 0; i < n; i++) mem[base + i] = rand_bits(32);
        end
        @(negedge BCLK);
        byte_idx = 0;
        n_bytes = 4 * n;
        rd_base = base;
        cyc_cnt = 0;
        slow = slw;
        dma_dir = dir;
        start_addr = long_t'(base * 4);
        word_count = xfer_cnt_t'(n);
        dma_ena = 1'b1;
        dev_on = 1'b1;
        wait_until_done(n * WORST_CYC + 100);
        if (!dir) check_mem(base, n);
        dma_ena = 1'b0;
        dev_on = 1'b0;
        repeat (6) @(negedge BCLK);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("errors: protocol %0d, data %0d, timeout %0d", proto_err, data_err, tmo_err);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        {dma_ena, dma_dir, flush, dreq, bgrant, data_in, start_addr, word_count} = '0;
        scsi_din = '0;
        dsack_ = 2'b11;
        sterm_ = 1'b1;
        grant_seen = 1'b0;
        n_bytes = 0;
        byte_idx = 0;
        gnt_dly = 0;
        CCRESET_ = 1'b0;
        repeat (8) @(posedge BCLK);
        @(negedge BCLK);
        CCRESET_ = 1'b1;
        assert (!breq && !bgack && !dack && !done && !stop_flush && as_ && ds_) else begin
            proto_err++;
            $display("control outputs not inactive after reset");
        end
        run_transfer(1'b0, 16, 5, 1'b0);
        run_transfer(1'b1, 32, 5, 1'b0);
        // slow memory against a fast device, more words than the FIFO holds
        run_transfer(1'b0, 0, `SDMAC_FIFO_DEPTH + 4, 1'b1);

        // flush after 4n+2 bytes with n = 3
        for (int i = 0; i < 64; i++) src[i] = 8'(rand_bits(8));
        byte_idx = 0;
        n_bytes = 14;
        cyc_cnt = 0;
        slow = 1'b0;
        dma_dir = 1'b0;
        start_addr = 32'hc0;
        word_count = 16'd100;
        dma_ena = 1'b1;
        dev_on = 1'b1;
        for (int i = 0; i < 400 && byte_idx < 14; i++) @(negedge BCLK);
        repeat (4) @(negedge BCLK);
        flush = 1'b1;
        for (int i = 0; i < 400 && !stop_flush; i++) @(negedge BCLK);
        if (!stop_flush) begin
            tmo_err++;
            $display("timeout waiting for stop_flush");
        end
        assert (cyc_cnt == 4) else begin
            data_err++;
            $display("FAIL flush cycles expected %h got %h", 4, cyc_cnt);
        end
        check_mem(48, 4);
        flush = 1'b0;
        dma_ena = 1'b0;
        dev_on = 1'b0;
        repeat (6) @(negedge BCLK);

        $display("errors: protocol %0d, data %0d, timeout %0d", proto_err, data_err, tmo_err);
        if (proto_err + data_err + tmo_err == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+verilog
verilog/sdmac_pkg.sv
verilog/scsi_port.sv
verilog/long_fifo.sv
verilog/cpu_bus_master.sv
verilog/sdmac_top.sv
tests/sdmac_tb.sv

/* Makefile */
# Verilator build and run for the SCSI DMA slice

VERILATOR ?= verilator
TOP       ?= sdmac_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= sources.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
